/* list.f */
modbus_frame_pkg.sv
modbus_image_pkg.sv
modbus_crc16.sv
modbus_rx_decode.sv
modbus_execute.sv
modbus_tx_result.sv
modbus_slave_top.sv
modbus_slave_assert.sv
tb_modbus_slave.sv

/* Bender.yml */
package:
  name: modbus_slave

sources:
  - modbus_frame_pkg.sv
  - modbus_image_pkg.sv
  - modbus_crc16.sv
  - modbus_rx_decode.sv
  - modbus_execute.sv
  - modbus_tx_result.sv
  - modbus_slave_top.sv
  - target: test
    files:
      - modbus_slave_assert.sv
      - tb_modbus_slave.sv

/* tb_modbus_slave.sv */
/*
 * Testbench for the Modbus RTU slave
 * Builds request frames, predicts responses from a register and coil model
 */
`timescale 1ns/1ns
`default_nettype none

module tb_modbus_slave
  import modbus_frame_pkg::*;
  import modbus_image_pkg::*;
();

  localparam mb_byte_t DEV_ADDR     = 8'h11;
  localparam int       RESP_TIMEOUT = 200;
  localparam int       QUIET_CYCLES = 40;

  logic        clk = 1'b0;
  logic        rst;
  mb_byte_t    rx_byte;
  logic        rx_valid;
  logic        frame_start;
  logic        frame_end;
  logic        tx_rdy;
  coil_vec_t   di_status;
  mb_byte_t    tx_byte;
  logic        tx_valid;
  coil_write_t do_write;
  logic        do_we;
  logic        crc_err;

  reg_word_t   model_regs [REG_WORDS];
  coil_vec_t   model_coils;
  mb_word_t    wr_words [MAX_WRITE_WORDS];
  mb_byte_t    frame_q[$];
  mb_byte_t    exp_q[$];
  mb_byte_t    got_q[$];
  logic        exp_we;
  coil_write_t exp_wr;
  coil_write_t we_data;
  int          err_pulses;
  int          we_pulses;
  int          error_cnt;
  int          check_cnt;

  modbus_slave_top dut0 (
    .clk         (clk),
    .rst         (rst),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .tx_rdy      (tx_rdy),
    .di_status   (di_status),
    .tx_byte     (tx_byte),
    .tx_valid    (tx_valid),
    .do_write    (do_write),
    .do_we       (do_we),
    .crc_err     (crc_err)
  );

  always #20 clk = ~clk;

  // Random back-pressure on the transmit side
  always @(posedge clk) begin
    #5;
    tx_rdy = 1'($urandom & 32'd1);
  end

  // Pulse monitor
  always @(negedge clk) begin
    if (crc_err) begin
      err_pulses++;
    end
    if (do_we) begin
      we_pulses++;
      we_data = do_write;
    end
  end

  // ====================================================================
  // Frame builder and reference model
  // ====================================================================
  function automatic mb_word_t frame_crc(input mb_byte_t q[$]);
    mb_word_t c;
    logic     fb;
    c = CRC_INIT;
    foreach (q[i]) begin
      for (int k = 0; k < 8; k++) begin
        fb = c[0] ^ q[i][k];
        c = c >> 1;
        if (fb) begin
          c = c ^ CRC_POLY;
        end
      end
    end
    return c;
  endfunction

  function automatic void build_frame(input mb_byte_t fc, input mb_word_t addr,
                                      input mb_word_t qv);
    mb_word_t crc;
    frame_q = '{DEV_ADDR, fc, addr[15:8], addr[7:0], qv[15:8], qv[7:0]};
    if (fc == FC_WRITE_MULTI) begin
      frame_q.push_back(mb_byte_t'(2 * qv));
      for (int i = 0; i < int'(qv); i++) begin
        frame_q.push_back(wr_words[i][15:8]);
        frame_q.push_back(wr_words[i][7:0]);
      end
    end
    crc = frame_crc(frame_q);
    frame_q.push_back(crc[7:0]);
    frame_q.push_back(crc[15:8]);
  endfunction

  function automatic void model_request(input mb_byte_t fc, input mb_word_t addr,
                                        input mb_word_t qv);
    int        a;
    int        q;
    int        bc;
    logic      echo;
    coil_vec_t src;
    coil_vec_t mask;
    mb_byte_t  b;
    mb_word_t  crc;
    a = int'(addr);
    q = int'(qv);
    echo = 1'b0;
    exp_q.delete();
    exp_we = 1'b0;
    case (fc)
      FC_READ_COILS, FC_READ_DISCRETE: begin
        if (q >= 1 && a + q <= COIL_BITS) begin
          src = (fc == FC_READ_COILS) ? model_coils : di_status;
          bc = (q + 7) / 8;
          exp_q = '{DEV_ADDR, fc, mb_byte_t'(bc)};
          // Point address + 8i + b lands in bit b of byte i
          for (int i = 0; i < bc; i++) begin
            b = '0;
            for (int k = 0; k < 8; k++) begin
              if (8 * i + k < q) begin
                b[k] = src[a + 8 * i + k];
              end
            end
            exp_q.push_back(b);
          end
        end
      end
      FC_READ_HOLDING: begin
        if (a + q <= REG_WORDS) begin
          exp_q = '{DEV_ADDR, fc, mb_byte_t'(2 * q)};
          for (int i = 0; i < q; i++) begin
            exp_q.push_back(model_regs[a + i][15:8]);
            exp_q.push_back(model_regs[a + i][7:0]);
          end
        end
      end
      FC_WRITE_COIL: begin
        if (a < COIL_BITS) begin
          mask = coil_vec_t'(1) << a;
          if (qv == COIL_ON) begin
            model_coils = model_coils | mask;
          end else begin
            model_coils = model_coils & ~mask;
          end
          exp_we = 1'b1;
          exp_wr.wdata = model_coils;
          exp_wr.wmask = mask;
          echo = 1'b1;
        end
      end
      FC_WRITE_REG: begin
        if (a < REG_WORDS) begin
          model_regs[a] = qv;
          echo = 1'b1;
        end
      end
      FC_WRITE_MULTI: begin
        if (q >= 1 && q <= MAX_WRITE_WORDS && a + q <= REG_WORDS) begin
          for (int i = 0; i < q; i++) begin
            model_regs[a + i] = wr_words[i];
          end
          echo = 1'b1;
        end
      end
      default: ;
    endcase
    if (echo) begin
      exp_q = '{DEV_ADDR, fc, addr[15:8], addr[7:0], qv[15:8], qv[7:0]};
    end
    if (exp_q.size() > 0) begin
      crc = frame_crc(exp_q);
      exp_q.push_back(crc[7:0]);
      exp_q.push_back(crc[15:8]);
    end
  endfunction

  // ====================================================================
  // Compare tasks
  // ====================================================================
  task automatic compare_byte(input string name, input mb_byte_t got, input mb_byte_t exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("** Error at %0t ns: %s got %02h expected %02h", $time, name, got, exp);
    end
  endtask

  task automatic compare_coils(input string name, input coil_write_t got,
                               input coil_write_t exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("** Error at %0t ns: %s got %016h expected %016h", $time, name, got, exp);
    end
  endtask

  task automatic compare_pulses(input string name, input int got, input int exp);
    check_cnt++;
    if (got != exp) begin
      error_cnt++;
      $display("** Error at %0t ns: %s pulses got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // ====================================================================
  // Frame transfer
  // ====================================================================
  task automatic send_frame();
    @(posedge clk);
    #5;
    err_pulses = 0;
    we_pulses = 0;
    frame_start = 1'b1;
    @(posedge clk);
    #5;
    frame_start = 1'b0;
    foreach (frame_q[i]) begin
      rx_byte = frame_q[i];
      rx_valid = 1'b1;
      @(posedge clk);
      #5;
    end
    rx_valid = 1'b0;
    frame_end = 1'b1;
    @(posedge clk);
    #5;
    frame_end = 1'b0;
  endtask

  task automatic collect_response();
    int cycles;
    int extra;
    cycles = 0;
    extra = 0;
    got_q.delete();
    while (got_q.size() < exp_q.size() && cycles < RESP_TIMEOUT) begin
      @(negedge clk);
      if (tx_valid) begin
        got_q.push_back(tx_byte);
      end
      cycles++;
    end
    if (got_q.size() < exp_q.size()) begin
      error_cnt++;
      $display("Timeout waiting for the response, got %0d of %0d bytes",
               got_q.size(), exp_q.size());
    end
    // Nothing may follow the final CRC byte
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clk);
      if (tx_valid) begin
        extra++;
      end
    end
    if (extra > 0) begin
      error_cnt++;
      $display("Unexpected tx_valid, %0d bytes beyond the expected response", extra);
    end
  endtask

  task automatic run_request(input mb_byte_t fc, input mb_word_t addr, input mb_word_t qv,
                             input logic bad_crc);
    int exp_err;
    build_frame(fc, addr, qv);
    if (bad_crc) begin
      frame_q[frame_q.size() - 1] = frame_q[frame_q.size() - 1] ^ 8'h5A;
      exp_q.delete();
      exp_we = 1'b0;
      exp_err = 1;
    end else begin
      model_request(fc, addr, qv);
      exp_err = 0;
    end
    send_frame();
    collect_response();
    foreach (exp_q[i]) begin
      if (i < got_q.size()) begin
        compare_byte($sformatf("tx_byte[%0d]", i), got_q[i], exp_q[i]);
      end
    end
    compare_pulses("crc_err", err_pulses, exp_err);
    compare_pulses("do_we", we_pulses, int'(exp_we));
    if (exp_we) begin
      compare_coils("do_write", we_data, exp_wr);
    end
  endtask

  // ====================================================================
  // Test sequence
  // ====================================================================
  initial begin
    int a;
    int n;
    int lo;
    int q;
    int c1;
    int c2;
    void'($urandom(32'h6c99));
    rst = 1'b1;
    rx_byte = '0;
    rx_valid = 1'b0;
    frame_start = 1'b0;
    frame_end = 1'b0;
    tx_rdy = 1'b0;
    di_status = '0;
    model_coils = '0;
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    error_cnt = 0;
    check_cnt = 0;
    repeat (2) @(posedge clk);
    #5;
    rst = 1'b0;

    // Single register write and read back
    a = $urandom_range(REG_WORDS - 1, 0);
    run_request(FC_WRITE_REG, mb_word_t'(a), mb_word_t'($urandom), 1'b0);
    run_request(FC_READ_HOLDING, mb_word_t'(a), 16'd1, 1'b0);

    // Block write, exact read, then a wider read around it
    n = $urandom_range(MAX_WRITE_WORDS, 1);
    a = $urandom_range(REG_WORDS - n, 0);
    foreach (wr_words[i]) begin
      wr_words[i] = mb_word_t'($urandom);
    end
    run_request(FC_WRITE_MULTI, mb_word_t'(a), mb_word_t'(n), 1'b0);
    run_request(FC_READ_HOLDING, mb_word_t'(a), mb_word_t'(n), 1'b0);
    lo = (a >= 2) ? a - 2 : 0;
    q = (lo + n + 4 <= REG_WORDS) ? n + 4 : REG_WORDS - lo;
    run_request(FC_READ_HOLDING, mb_word_t'(lo), mb_word_t'(q), 1'b0);

    // Coils on, on, off, then read back
    c1 = $urandom_range(COIL_BITS - 1, 0);
    c2 = (c1 + 5) % COIL_BITS;
    run_request(FC_WRITE_COIL, mb_word_t'(c1), COIL_ON, 1'b0);
    run_request(FC_WRITE_COIL, mb_word_t'(c2), COIL_ON, 1'b0);
    run_request(FC_WRITE_COIL, mb_word_t'(c1), 16'h0000, 1'b0);
    run_request(FC_READ_COILS, 16'd0, mb_word_t'(COIL_BITS), 1'b0);
    a = $urandom_range(COIL_BITS - 1, 0);
    run_request(FC_READ_COILS, mb_word_t'(a), mb_word_t'($urandom_range(COIL_BITS - a, 1)),
                1'b0);

    // Discrete inputs over a random range
    @(posedge clk);
    #5;
    di_status = coil_vec_t'($urandom);
    a = $urandom_range(COIL_BITS - 1, 0);
    run_request(FC_READ_DISCRETE, mb_word_t'(a), mb_word_t'($urandom_range(COIL_BITS - a, 1)),
                1'b0);

    // Corrupted CRC, unknown code and a read past the image
    run_request(FC_READ_HOLDING, mb_word_t'(a), 16'd2, 1'b1);
    run_request(8'h07, 16'd0, 16'd1, 1'b0);
    run_request(FC_READ_HOLDING, 16'd60, 16'd8, 1'b0);

    $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* modbus_slave_assert.sv */
/*
 * Bound checks on the Modbus slave strobes
 */
`timescale 1ns/1ns
`default_nettype none

module modbus_slave_assert (
  input logic clk,
  input logic rst,
  input logic tx_valid,
  input logic tx_rdy,
  input logic do_we,
  input logic busy
);

  // No byte leaves while the receiver holds off
  a_tx_paced: assert property (@(posedge clk) disable iff (rst) tx_valid |-> tx_rdy)
    else $error("tx_valid high while tx_rdy low");

  a_we_pulse: assert property (@(posedge clk) disable iff (rst) do_we |=> !do_we)
    else $error("do_we held for more than one cycle");

  // Bytes only go out inside a response
  a_tx_in_resp: assert property (@(posedge clk) disable iff (rst) !busy |-> !tx_valid)
    else $error("tx_valid high while busy low");

endmodule

bind modbus_slave_top modbus_slave_assert u_assert (
  .clk      (clk),
  .rst      (rst),
  .tx_valid (tx_valid),
  .tx_rdy   (tx_rdy),
  .do_we    (do_we),
  .busy     (busy)
);

`default_nettype wire

/* modbus_slave_top.sv */
/*
 * Modbus RTU slave top level
 * Connects the frame decoder, the request executor and the response generator
 */
`timescale 1ns/1ns
`default_nettype none

module modbus_slave_top
  import modbus_frame_pkg::*;
  import modbus_image_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  mb_byte_t    rx_byte,
  input  logic        rx_valid,
  input  logic        frame_start,
  input  logic        frame_end,
  input  logic        tx_rdy,
  input  coil_vec_t   di_status,
  output mb_byte_t    tx_byte,
  output logic        tx_valid,
  output coil_write_t do_write,
  output logic        do_we,
  output logic        crc_err
);

  mb_req_t    req;
  logic       req_valid;
  mb_req_t    resp_req;
  logic       resp_start;
  logic [7:0] rd_idx;
  mb_byte_t   rd_byte;
  logic       busy;

  modbus_rx_decode u_decode (
    .clk         (clk),
    .rst         (rst),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .busy        (busy),
    .req         (req),
    .req_valid   (req_valid),
    .crc_err     (crc_err)
  );

  modbus_execute u_execute (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .req_valid  (req_valid),
    .rd_idx     (rd_idx),
    .di_status  (di_status),
    .resp_req   (resp_req),
    .resp_start (resp_start),
    .rd_byte    (rd_byte),
    .do_write   (do_write),
    .do_we      (do_we)
  );

  modbus_tx_result u_result (
    .clk        (clk),
    .rst        (rst),
    .resp_req   (resp_req),
    .resp_start (resp_start),
    .rd_byte    (rd_byte),
    .tx_rdy     (tx_rdy),
    .rd_idx     (rd_idx),
    .tx_byte    (tx_byte),
    .tx_valid   (tx_valid),
    .busy       (busy)
  );

endmodule

`default_nettype wire

/* modbus_tx_result.sv */
/*
 * Modbus response generator
 * Sequences the response bytes on tx_rdy and appends the CRC, low byte first
 */
`timescale 1ns/1ns
`default_nettype none

module modbus_tx_result
  import modbus_frame_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  mb_req_t    resp_req,
  input  logic       resp_start,
  input  mb_byte_t   rd_byte,
  input  logic       tx_rdy,
  output logic [7:0] rd_idx,
  output mb_byte_t   tx_byte,
  output logic       tx_valid,
  output logic       busy
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_BODY,
    S_CRC_LO,
    S_CRC_HI
  } tx_state_e;

  tx_state_e  state;
  logic [7:0] pos;
  logic       is_read;
  mb_word_t   bc_wide;
  mb_byte_t   byte_cnt;
  logic [7:0] body_last;
  mb_byte_t   body_byte;
  mb_word_t   crc;

  assign is_read = (resp_req.func == FC_READ_COILS) || (resp_req.func == FC_READ_DISCRETE)
                   || (resp_req.func == FC_READ_HOLDING);

  // Byte count: whole bytes of bits, or two per register
  assign bc_wide   = (resp_req.func == FC_READ_HOLDING) ? {resp_req.qty_val[14:0], 1'b0}
                                                        : ((resp_req.qty_val + 16'd7) >> 3);
  assign byte_cnt  = bc_wide[7:0];
  assign body_last = is_read ? (byte_cnt + 8'd2) : 8'd5;
  assign rd_idx    = pos - 8'd3;

  // Header, then read data or the echoed write fields
  always_comb begin
    case (pos)
      8'd0: body_byte = resp_req.dev_addr;
      8'd1: body_byte = resp_req.func;
      8'd2: body_byte = is_read ? byte_cnt : resp_req.start_addr[15:8];
      8'd3: body_byte = is_read ? rd_byte : resp_req.start_addr[7:0];
      8'd4: body_byte = is_read ? rd_byte : resp_req.qty_val[15:8];
      8'd5: body_byte = is_read ? rd_byte : resp_req.qty_val[7:0];
      default: body_byte = rd_byte;
    endcase
  end

  always_comb begin
    case (state)
      S_CRC_LO: tx_byte = crc[7:0];
      S_CRC_HI: tx_byte = crc[15:8];
      default:  tx_byte = body_byte;
    endcase
  end

  assign tx_valid = (state != S_IDLE) && tx_rdy;
  // Cover the hand-off cycle so no new frame starts under a pending response
  assign busy     = (state != S_IDLE) || resp_start;

  modbus_crc16 u_crc (
    .clk   (clk),
    .rst   (rst),
    .clr   (resp_start),
    .data  (tx_byte),
    .valid (tx_valid && (state == S_BODY)),
    .crc   (crc)
  );

  // ====================================================================
  // Response sequencer
  // ====================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
      pos   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          pos <= '0;
          if (resp_start) begin
            state <= S_BODY;
          end
        end
        S_BODY: begin
          if (tx_rdy) begin
            if (pos == body_last) begin
              state <= S_CRC_LO;
            end else begin
              pos <= pos + 8'd1;
            end
          end
        end
        S_CRC_LO: if (tx_rdy) state <= S_CRC_HI;
        S_CRC_HI: if (tx_rdy) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* modbus_execute.sv */
/*
 * Modbus request executor
 * Owns the holding registers and coils, range-checks requests, applies writes
 * and serves read data bytes to the response generator
 */
`timescale 1ns/1ns
`default_nettype none

module modbus_execute
  import modbus_frame_pkg::*;
  import modbus_image_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  mb_req_t     req,
  input  logic        req_valid,
  input  logic [7:0]  rd_idx,
  input  coil_vec_t   di_status,
  output mb_req_t     resp_req,
  output logic        resp_start,
  output mb_byte_t    rd_byte,
  output coil_write_t do_write,
  output logic        do_we
);

  reg_word_t   regs [REG_WORDS];
  logic [16:0] req_end;
  logic        qty_nz;
  logic        req_ok;
  coil_vec_t   coil_mask;
  reg_word_t   rd_word;
  coil_vec_t   bit_src;
  coil_vec_t   bit_shift;
  logic [10:0] bit_pos;

  assign req_end   = {1'b0, req.start_addr} + {1'b0, req.qty_val};
  assign qty_nz    = (req.qty_val != 16'd0);
  assign coil_mask = coil_vec_t'(1) << req.start_addr[4:0];

  // Range checks for every supported code
  always_comb begin
    case (req.func)
      FC_READ_COILS, FC_READ_DISCRETE: req_ok = qty_nz && (req_end <= 17'(COIL_BITS));
      FC_READ_HOLDING: req_ok = (req_end <= 17'(REG_WORDS));
      FC_WRITE_COIL:   req_ok = (req.start_addr < 16'(COIL_BITS));
      FC_WRITE_REG:    req_ok = (req.start_addr < 16'(REG_WORDS));
      FC_WRITE_MULTI: begin
        req_ok = qty_nz && (req.qty_val <= 16'(MAX_WRITE_WORDS))
                 && ({8'h00, req.byte_cnt} == {req.qty_val[14:0], 1'b0})
                 && (req_end <= 17'(REG_WORDS));
      end
      default: req_ok = 1'b0;
    endcase
  end

  // ====================================================================
  // Writes and response hand-off
  // ====================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < REG_WORDS; i++) begin
        regs[i] <= '0;
      end
      do_write   <= '0;
      do_we      <= 1'b0;
      resp_start <= 1'b0;
    end else begin
      do_we      <= 1'b0;
      resp_start <= req_valid && req_ok;
      if (req_valid && req_ok) begin
        case (req.func)
          FC_WRITE_REG: regs[req.start_addr[5:0]] <= req.qty_val;
          FC_WRITE_MULTI: begin
            for (int i = 0; i < MAX_WRITE_WORDS; i++) begin
              if (i < req.qty_val) begin
                regs[req.start_addr[5:0] + reg_idx_t'(i)] <= req.wr_data[i];
              end
            end
          end
          FC_WRITE_COIL: begin
            do_write.wmask <= coil_mask;
            if (req.qty_val == COIL_ON) begin
              do_write.wdata <= do_write.wdata | coil_mask;
            end else begin
              do_write.wdata <= do_write.wdata & ~coil_mask;
            end
            do_we <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // Request copy held for the response generator
  always_ff @(posedge clk) begin
    if (req_valid && req_ok) begin
      resp_req <= req;
    end
  end

  // ====================================================================
  // Read data bytes
  // ====================================================================
  assign rd_word   = regs[resp_req.start_addr[5:0] + reg_idx_t'(rd_idx[7:1])];
  assign bit_src   = (resp_req.func == FC_READ_COILS) ? do_write.wdata : di_status;
  assign bit_shift = bit_src >> resp_req.start_addr[4:0];

  always_comb begin
    rd_byte = '0;
    bit_pos = '0;
    if (resp_req.func == FC_READ_HOLDING) begin
      rd_byte = rd_idx[0] ? rd_word[7:0] : rd_word[15:8];
    end else begin
      // Bit b of byte i is point address + 8i + b, zero past the quantity
      for (int b = 0; b < 8; b++) begin
        bit_pos = {rd_idx, 3'(b)};
        if (bit_pos < resp_req.qty_val) begin
          rd_byte[b] = bit_shift[bit_pos[4:0]];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* modbus_rx_decode.sv */
/*
 * Modbus RTU receive decoder
 * Collects one frame, checks the CRC residue and extracts the request fields
 */
`timescale 1ns/1ns
`default_nettype none

module modbus_rx_decode
  import modbus_frame_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  mb_byte_t rx_byte,
  input  logic     rx_valid,
  input  logic     frame_start,
  input  logic     frame_end,
  input  logic     busy,
  output mb_req_t  req,
  output logic     req_valid,
  output logic     crc_err
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_COLLECT,
    S_CHECK
  } rx_state_e;

  rx_state_e state;
  logic [7:0] cnt;
  logic [7:0] wpos;
  logic       start_ok;
  logic       byte_in;
  logic       len_ok;
  mb_word_t   crc;

  assign start_ok = (state == S_IDLE) && frame_start && !busy;
  assign byte_in  = (state == S_COLLECT) && rx_valid;
  assign wpos     = cnt - 8'd7;
  assign len_ok   = (cnt >= 8'(MIN_FRAME_LEN));

  // Running CRC over every byte, the CRC pair included
  modbus_crc16 u_crc (
    .clk   (clk),
    .rst   (rst),
    .clr   (start_ok),
    .data  (rx_byte),
    .valid (byte_in),
    .crc   (crc)
  );

  // A good frame leaves a zero residue
  assign req_valid = (state == S_CHECK) && len_ok && (crc == 16'h0000);
  assign crc_err   = (state == S_CHECK) && len_ok && (crc != 16'h0000);

  // ====================================================================
  // Frame state and byte counter
  // ====================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          cnt <= '0;
          if (start_ok) begin
            state <= S_COLLECT;
          end
        end
        S_COLLECT: begin
          // Saturate so long frames cannot wrap into a short one
          if (rx_valid && cnt != 8'hFF) begin
            cnt <= cnt + 8'd1;
          end
          if (frame_end) begin
            state <= S_CHECK;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // ====================================================================
  // Field placement by byte position
  // ====================================================================
  always_ff @(posedge clk) begin
    if (byte_in) begin
      case (cnt)
        8'd0: req.dev_addr <= rx_byte;
        8'd1: req.func <= mb_func_e'(rx_byte);
        8'd2: req.start_addr[15:8] <= rx_byte;
        8'd3: req.start_addr[7:0] <= rx_byte;
        8'd4: req.qty_val[15:8] <= rx_byte;
        8'd5: req.qty_val[7:0] <= rx_byte;
        8'd6: req.byte_cnt <= rx_byte;
        default: begin
          // Write payload, high byte of each word first
          if (wpos < 8'd16) begin
            if (wpos[0]) begin
              req.wr_data[wpos[3:1]][7:0] <= rx_byte;
            end else begin
              req.wr_data[wpos[3:1]][15:8] <= rx_byte;
            end
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* modbus_crc16.sv */
/*
 * Byte-serial CRC-16 engine for Modbus RTU
 * Shared by the receive check and the response generator
 */
`timescale 1ns/1ns
`default_nettype none

module modbus_crc16
  import modbus_frame_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     clr,
  input  mb_byte_t data,
  input  logic     valid,
  output mb_word_t crc
);

  // Eight LSB-first shift steps for one byte
  function automatic mb_word_t crc_step(mb_word_t c, mb_byte_t d);
    mb_word_t x;
    x = c ^ {8'h00, d};
    for (int k = 0; k < 8; k++) begin
      x = x[0] ? ((x >> 1) ^ CRC_POLY) : (x >> 1);
    end
    return x;
  endfunction

  always_ff @(posedge clk) begin
    if (rst || clr) begin
      crc <= CRC_INIT;
    end else if (valid) begin
      crc <= crc_step(crc, data);
    end
  end

endmodule

`default_nettype wire

/* modbus_image_pkg.sv */
/*
 * Modbus slave process image definitions
 * Holding-register image and coil output types
 */
`default_nettype none

package modbus_image_pkg;

  localparam int REG_WORDS = 64;
  localparam int COIL_BITS = 32;

  typedef logic [5:0]           reg_idx_t;
  typedef logic [15:0]          reg_word_t;
  typedef logic [COIL_BITS-1:0] coil_vec_t;

  // Coil output state with the mask of the last write
  typedef struct packed {
    coil_vec_t wdata;
    coil_vec_t wmask;
  } coil_write_t;

endpackage

`default_nettype wire

/* modbus_frame_pkg.sv */
/*
 * Modbus RTU frame format definitions
 * Byte and word types, function codes, the decoded request and CRC constants
 */
`default_nettype none

package modbus_frame_pkg;

  typedef logic [7:0]  mb_byte_t;
  typedef logic [15:0] mb_word_t;

  // Function codes served by the slave
  typedef enum logic [7:0] {
    FC_READ_COILS    = 8'h01,
    FC_READ_DISCRETE = 8'h02,
    FC_READ_HOLDING  = 8'h03,
    FC_WRITE_COIL    = 8'h05,
    FC_WRITE_REG     = 8'h06,
    FC_WRITE_MULTI   = 8'h10
  } mb_func_e;

  // Frame limits
  localparam int MIN_FRAME_LEN   = 4;
  localparam int MAX_WRITE_WORDS = 8;

  // CRC-16 in reflected form
  localparam mb_word_t CRC_INIT = 16'hFFFF;
  localparam mb_word_t CRC_POLY = 16'hA001;

  // Value that switches a single coil on
  localparam mb_word_t COIL_ON = 16'hFF00;

  // Decoded request, 184 bits
  typedef struct packed {
    mb_byte_t                            dev_addr;
    mb_func_e                            func;
    mb_word_t                            start_addr;
    mb_word_t                            qty_val;
    mb_byte_t                            byte_cnt;
    mb_word_t [MAX_WRITE_WORDS-1:0]      wr_data;
  } mb_req_t;

endpackage

`default_nettype wire
